//--- Makefile
TOP := tb_ili9341_controller

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- design/command_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module command_sequencer #(
    parameter int unsigned DELAY_CYCLES = lcd_pkg::DEFAULT_DELAY_CYCLES
) (
    input  logic           clk,
    input  logic           rst,
    spi_word_if.source     link,
    input  lcd_pkg::byte_t pixel_byte,
    input  logic           frame_done,
    output logic           take
);
    import lcd_pkg::*;
    `include "lcd_init_table.svh"

    seq_state_t    state;
    seq_state_t    wait_next;   // Where a wait state goes when done
    init_index_t   init_idx;
    window_index_t win_idx;     // Also steps the rotation pair
    delay_t        delay_cnt;
    credit_t       credits;
    credit_t       in_flight;   // Words seen on the link and not yet credited
    logic          have_credit;
    logic          issue;
    logic          delay_done;
    spi_word_t     next_word;

    // Full 320x240 landscape address window
    function automatic spi_word_t window_word(window_index_t idx);
        case (idx)
            4'd0:    return {DC_CMD,  CMD_CASET};
            4'd1:    return {DC_DATA, 8'h00};    // Column start
            4'd2:    return {DC_DATA, 8'h00};
            4'd3:    return {DC_DATA, 8'h01};    // Column end 319
            4'd4:    return {DC_DATA, 8'h3F};
            4'd5:    return {DC_CMD,  CMD_PASET};
            4'd6:    return {DC_DATA, 8'h00};    // Page start
            4'd7:    return {DC_DATA, 8'h00};
            4'd8:    return {DC_DATA, 8'h00};    // Page end 239
            4'd9:    return {DC_DATA, 8'hEF};
            default: return {DC_CMD,  CMD_RAMWR};
        endcase
    endfunction

    assign have_credit = (credits != '0);
    assign delay_done  = (delay_cnt == delay_t'(DELAY_CYCLES - 1));

    // ------------------------------------------------------------
    // Word select and issue decision
    // ------------------------------------------------------------
    always_comb begin
        issue     = 1'b0;
        wait_next = state;
        next_word = {DC_CMD, CMD_SWRESET};
        case (state)
            SEND_RESET: issue = have_credit;
            SEND_INIT: begin
                issue     = have_credit;
                next_word = INIT_TABLE[init_idx];
            end
            DISPLAY_ON: begin
                issue     = have_credit;
                next_word = {DC_CMD, CMD_DISPON};
            end
            SET_ROTATION: begin
                issue     = have_credit;
                next_word = (win_idx == '0) ? {DC_CMD, CMD_MADCTL} : {DC_DATA, MADCTL_ROTATION};
            end
            SET_WINDOW: begin
                issue     = have_credit;
                next_word = window_word(win_idx);
            end
            FRAME_LOOP: begin
                issue     = have_credit && !frame_done;  // Hold off new bytes only
                next_word = {DC_DATA, pixel_byte};
            end
            WAIT_RESET: wait_next = SEND_INIT;
            WAIT_INIT:  wait_next = DISPLAY_ON;
            WAIT_ON:    wait_next = SET_ROTATION;
            default: ;
        endcase
    end

    // ------------------------------------------------------------
    // State, indices and delay counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= START;
            init_idx  <= '0;
            win_idx   <= '0;
            delay_cnt <= '0;
        end else begin
            case (state)
                START:      state <= SEND_RESET;
                SEND_RESET: if (issue) state <= WAIT_RESET;
                SEND_INIT: begin
                    if (issue) begin
                        if (init_idx == init_index_t'(INIT_LEN - 1)) begin
                            init_idx <= '0;
                            state    <= WAIT_INIT;
                        end else begin
                            init_idx <= init_idx + init_index_t'(1);
                        end
                    end
                end
                DISPLAY_ON: if (issue) state <= WAIT_ON;
                SET_ROTATION: begin
                    if (issue) begin
                        if (win_idx == window_index_t'(1)) begin
                            win_idx <= '0;
                            state   <= SET_WINDOW;
                        end else begin
                            win_idx <= win_idx + window_index_t'(1);
                        end
                    end
                end
                SET_WINDOW: begin
                    if (issue) begin
                        if (win_idx == window_index_t'(WINDOW_LEN - 1)) begin
                            win_idx <= '0;
                            state   <= FRAME_LOOP;
                        end else begin
                            win_idx <= win_idx + window_index_t'(1);
                        end
                    end
                end
                FRAME_LOOP: if (frame_done) state <= WAIT_FRAME;
                WAIT_FRAME: if (!frame_done) state <= FRAME_LOOP;
                default: begin
                    // Count only once the last word is out on the wire
                    if (credits == credit_t'(SPI_CREDITS)) begin
                        if (delay_done) begin
                            delay_cnt <= '0;
                            state     <= wait_next;
                        end else begin
                            delay_cnt <= delay_cnt + delay_t'(1);
                        end
                    end
                end
            endcase
        end
    end

    // ------------------------------------------------------------
    // Link outputs and credit counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            link.valid <= 1'b0;
            take       <= 1'b0;
            credits    <= credit_t'(SPI_CREDITS);
        end else begin
            link.valid <= issue;
            take       <= issue && (state == FRAME_LOOP);  // Pixel byte consumed
            credits    <= credits + credit_t'(link.credit) - credit_t'(issue);
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            link.word <= next_word;
        end
    end

    // Outstanding words as seen on the link pins
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + credit_t'(link.valid) - credit_t'(link.credit);
        end
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (rst)
        credits <= credit_t'(SPI_CREDITS)
    );

    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (rst)
        link.valid |-> in_flight < credit_t'(SPI_CREDITS)
    );

endmodule

`default_nettype wire

//--- design/ili9341_controller.sv
`timescale 1ns/1ns
`default_nettype none

module ili9341_controller #(
    parameter int unsigned DELAY_CYCLES = lcd_pkg::DEFAULT_DELAY_CYCLES
) (
    input  logic            clk,
    input  logic            rst,
    input  lcd_pkg::pixel_t input_data,
    input  logic            frame_done,
    output logic            spi_mosi,
    output logic            spi_sck,
    output logic            spi_cs,
    output logic            spi_dc,
    output logic            data_clk
);
    import lcd_pkg::*;

    byte_t pixel_byte;  // Selected half of input_data
    logic  take;

    spi_word_if link0 ();

    command_sequencer #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) seq0 (
        .clk        (clk),
        .rst        (rst),
        .link       (link0.source),
        .pixel_byte (pixel_byte),
        .frame_done (frame_done),
        .take       (take)
    );

    spi_serializer ser0 (
        .clk      (clk),
        .rst      (rst),
        .link     (link0.sink),
        .spi_mosi (spi_mosi),
        .spi_sck  (spi_sck),
        .spi_cs   (spi_cs),
        .spi_dc   (spi_dc)
    );

    pixel_streamer pix0 (
        .clk        (clk),
        .rst        (rst),
        .input_data (input_data),
        .take       (take),
        .pixel_byte (pixel_byte),
        .data_clk   (data_clk)
    );

endmodule

`default_nettype wire

//--- design/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    typedef logic [7:0]  byte_t;          // SPI payload byte
    typedef logic [8:0]  spi_word_t;      // {dc, byte}, dc=1 for data
    typedef logic [15:0] pixel_t;         // RGB565
    typedef logic [6:0]  init_index_t;    // Init table index
    typedef logic [3:0]  window_index_t;  // Address window index
    typedef logic [1:0]  credit_t;        // Link credit counter
    typedef logic [21:0] delay_t;         // Power-up delay counter

    localparam logic DC_CMD  = 1'b0;
    localparam logic DC_DATA = 1'b1;

    localparam int unsigned INIT_LEN             = 83;
    localparam int unsigned WINDOW_LEN           = 11;       // CASET x5, PASET x5, RAMWR
    localparam int unsigned SPI_CREDITS          = 1;
    localparam int unsigned DEFAULT_DELAY_CYCLES = 2500000;  // 100 ms at 25 MHz

    // ------------------------------------------------------------
    // ILI9341 commands
    // ------------------------------------------------------------
    localparam byte_t CMD_SWRESET  = 8'h01;  // Software reset
    localparam byte_t CMD_SLPOUT   = 8'h11;  // Sleep out
    localparam byte_t CMD_GAMMASET = 8'h26;  // Gamma curve select
    localparam byte_t CMD_DISPON   = 8'h29;  // Display on
    localparam byte_t CMD_CASET    = 8'h2A;  // Column address
    localparam byte_t CMD_PASET    = 8'h2B;  // Page address
    localparam byte_t CMD_RAMWR    = 8'h2C;  // Memory write
    localparam byte_t CMD_MADCTL   = 8'h36;  // Memory access control
    localparam byte_t CMD_VSCRSADD = 8'h37;  // Vertical scroll start
    localparam byte_t CMD_PIXFMT   = 8'h3A;  // Pixel format
    localparam byte_t CMD_FRMCTR1  = 8'hB1;  // Frame rate, normal mode
    localparam byte_t CMD_DFUNCTR  = 8'hB6;  // Display function control
    localparam byte_t CMD_PWCTR1   = 8'hC0;  // Power control 1
    localparam byte_t CMD_PWCTR2   = 8'hC1;  // Power control 2
    localparam byte_t CMD_VMCTR1   = 8'hC5;  // VCOM control 1
    localparam byte_t CMD_VMCTR2   = 8'hC7;  // VCOM control 2
    localparam byte_t CMD_PWCTRA   = 8'hCB;  // Power control A
    localparam byte_t CMD_PWCTRB   = 8'hCF;  // Power control B
    localparam byte_t CMD_GMCTRP1  = 8'hE0;  // Positive gamma
    localparam byte_t CMD_GMCTRN1  = 8'hE1;  // Negative gamma
    localparam byte_t CMD_DTCA     = 8'hE8;  // Driver timing A
    localparam byte_t CMD_DTCB     = 8'hEA;  // Driver timing B
    localparam byte_t CMD_PWSEQ    = 8'hED;  // Power-on sequence
    localparam byte_t CMD_GAMMA3EN = 8'hF2;  // 3-gamma enable
    localparam byte_t CMD_PRC      = 8'hF7;  // Pump ratio control

    // MADCTL flag bits
    localparam byte_t MADCTL_MY  = 8'h80;  // Row order flipped
    localparam byte_t MADCTL_MX  = 8'h40;  // Column order flipped
    localparam byte_t MADCTL_MV  = 8'h20;  // Row/column exchange
    localparam byte_t MADCTL_BGR = 8'h08;  // BGR panel order

    // Landscape, 320x240
    localparam byte_t MADCTL_ROTATION = MADCTL_MY | MADCTL_MX | MADCTL_MV | MADCTL_BGR;

    // ------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        START,
        SEND_RESET,
        WAIT_RESET,
        SEND_INIT,
        WAIT_INIT,
        DISPLAY_ON,
        WAIT_ON,
        SET_ROTATION,
        SET_WINDOW,
        FRAME_LOOP,
        WAIT_FRAME
    } seq_state_t;

endpackage

`default_nettype wire

//--- design/pixel_streamer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_streamer (
    input  logic            clk,
    input  logic            rst,
    input  lcd_pkg::pixel_t input_data,
    input  logic            take,
    output lcd_pkg::byte_t  pixel_byte,
    output logic            data_clk
);
    import lcd_pkg::*;

    logic low_sel;  // 0: high byte pending, 1: low byte pending

    // Flip after each byte the sequencer has taken
    always_ff @(posedge clk) begin
        if (rst) begin
            low_sel <= 1'b0;
        end else if (take) begin
            low_sel <= !low_sel;
        end
    end

    // High byte goes first on the wire
    always_comb begin
        if (low_sel) begin
            pixel_byte = input_data[7:0];
        end else begin
            pixel_byte = input_data[15:8];
        end
    end

    // Falling edge tells the source to present the next pixel
    assign data_clk = low_sel;

endmodule

`default_nettype wire

//--- design/spi_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module spi_serializer (
    input  logic       clk,
    input  logic       rst,
    spi_word_if.sink   link,
    output logic       spi_mosi,
    output logic       spi_sck,
    output logic       spi_cs,
    output logic       spi_dc
);
    import lcd_pkg::*;

    byte_t      shreg;    // MSB drives mosi
    logic [2:0] bit_cnt;
    logic       busy;     // From accept until credit is returned
    logic       credit_q;

    assign spi_mosi    = shreg[7];
    assign link.credit = credit_q;

    // ------------------------------------------------------------
    // Shift engine, sck = clk/2, mode 0
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            shreg    <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
            credit_q <= 1'b0;
            spi_sck  <= 1'b0;
            spi_cs   <= 1'b1;
            spi_dc   <= 1'b0;
        end else begin
            credit_q <= 1'b0;
            if (!busy) begin
                if (link.valid) begin
                    busy    <= 1'b1;
                    spi_cs  <= 1'b0;             // Falls the cycle after valid
                    spi_dc  <= link.word[8];
                    shreg   <= link.word[7:0];
                    bit_cnt <= '0;
                end
            end else if (!spi_cs) begin
                if (!spi_sck) begin
                    spi_sck <= 1'b1;             // Display samples here
                end else begin
                    spi_sck <= 1'b0;
                    if (bit_cnt == 3'd7) begin
                        spi_cs <= 1'b1;          // Last bit done
                    end else begin
                        shreg   <= {shreg[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 3'd1;
                    end
                end
            end else begin
                // cs already high, hand the credit back
                credit_q <= 1'b1;
                busy     <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // The source must wait for the credit before the next word
    // ------------------------------------------------------------
    a_no_valid_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        link.valid |-> !busy
    );

endmodule

`default_nettype wire

//--- design/spi_word_if.sv
`timescale 1ns/1ns
`default_nettype none

// Word link from sequencer to serializer, one credit in flight
interface spi_word_if;
    import lcd_pkg::*;

    logic      valid;   // One-cycle pulse, spends a credit
    spi_word_t word;    // {dc, byte}
    logic      credit;  // One-cycle pulse, word fully shifted out

    modport source (
        output valid,
        output word,
        input  credit
    );

    modport sink (
        input  valid,
        input  word,
        output credit
    );

endinterface

`default_nettype wire

//--- include/lcd_init_table.svh
`ifndef LCD_INIT_TABLE_SVH
`define LCD_INIT_TABLE_SVH

// Power, VCOM, format and gamma setup sent once after software reset
localparam spi_word_t INIT_TABLE [INIT_LEN] = '{
    {DC_CMD,  CMD_PWCTRA},
    {DC_DATA, 8'h39},
    {DC_DATA, 8'h2C},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'h34},
    {DC_DATA, 8'h02},
    {DC_CMD,  CMD_PWCTRB},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'hC1},
    {DC_DATA, 8'h30},
    {DC_CMD,  CMD_DTCA},
    {DC_DATA, 8'h85},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'h78},
    {DC_CMD,  CMD_DTCB},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'h00},
    {DC_CMD,  CMD_PWSEQ},
    {DC_DATA, 8'h64},
    {DC_DATA, 8'h03},
    {DC_DATA, 8'h12},
    {DC_DATA, 8'h81},
    {DC_CMD,  CMD_PRC},
    {DC_DATA, 8'h20},
    {DC_CMD,  CMD_PWCTR1},
    {DC_DATA, 8'h23},             // VRH 4.60 V
    {DC_CMD,  CMD_PWCTR2},
    {DC_DATA, 8'h10},
    {DC_CMD,  CMD_VMCTR1},
    {DC_DATA, 8'h3E},
    {DC_DATA, 8'h28},
    {DC_CMD,  CMD_VMCTR2},
    {DC_DATA, 8'h86},
    {DC_CMD,  CMD_MADCTL},
    {DC_DATA, 8'h48},             // Portrait until MADCTL is sent again
    {DC_CMD,  CMD_VSCRSADD},
    {DC_DATA, 8'h00},
    {DC_CMD,  CMD_PIXFMT},
    {DC_DATA, 8'h55},             // 16 bits per pixel
    {DC_CMD,  CMD_FRMCTR1},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'h18},             // 79 Hz
    {DC_CMD,  CMD_DFUNCTR},
    {DC_DATA, 8'h08},
    {DC_DATA, 8'h82},
    {DC_DATA, 8'h27},
    {DC_CMD,  CMD_GAMMA3EN},
    {DC_DATA, 8'h00},
    {DC_CMD,  CMD_GAMMASET},
    {DC_DATA, 8'h01},
    {DC_CMD,  CMD_GMCTRP1},
    {DC_DATA, 8'h0F},
    {DC_DATA, 8'h31},
    {DC_DATA, 8'h2B},
    {DC_DATA, 8'h0C},
    {DC_DATA, 8'h0E},
    {DC_DATA, 8'h08},
    {DC_DATA, 8'h4E},
    {DC_DATA, 8'hF1},
    {DC_DATA, 8'h37},
    {DC_DATA, 8'h07},
    {DC_DATA, 8'h10},
    {DC_DATA, 8'h03},
    {DC_DATA, 8'h0E},
    {DC_DATA, 8'h09},
    {DC_DATA, 8'h00},
    {DC_CMD,  CMD_GMCTRN1},
    {DC_DATA, 8'h00},
    {DC_DATA, 8'h0E},
    {DC_DATA, 8'h14},
    {DC_DATA, 8'h03},
    {DC_DATA, 8'h11},
    {DC_DATA, 8'h07},
    {DC_DATA, 8'h31},
    {DC_DATA, 8'hC1},
    {DC_DATA, 8'h48},
    {DC_DATA, 8'h08},
    {DC_DATA, 8'h0F},
    {DC_DATA, 8'h0C},
    {DC_DATA, 8'h31},
    {DC_DATA, 8'h36},
    {DC_DATA, 8'h0F},
    {DC_CMD,  CMD_SLPOUT}         // Needs the long wait after it
};

`endif

//--- project.f
+incdir+include
design/lcd_pkg.sv
design/spi_word_if.sv
design/spi_serializer.sv
design/pixel_streamer.sv
design/command_sequencer.sv
design/ili9341_controller.sv
verification/tb_ili9341_controller.sv

//--- verification/tb_ili9341_controller.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ili9341_controller;
    import lcd_pkg::*;
    `undef LCD_INIT_TABLE_SVH
    `include "lcd_init_table.svh"

    localparam int CLK_PERIOD    = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 10;
    localparam int DELAY_CYCLES  = 50;
    localparam int LAST_INIT     = int'(INIT_LEN);     // Word 83 is SLPOUT
    localparam int DISPON_POS    = LAST_INIT + 1;
    localparam int WINDOW_BASE   = DISPON_POS + 3;     // After DISPON, MADCTL and E8h
    localparam int PIXEL_BASE    = WINDOW_BASE + 11;
    localparam int NUM_PIXELS    = 24;
    localparam int PAUSE_PIXEL   = 20;                 // Pause while its high byte is out
    localparam int PAUSE_CYCLES  = 200;
    localparam int TOTAL_WORDS   = PIXEL_BASE + 2 * NUM_PIXELS;
    localparam int WATCHDOG_CYCLES = 3 * DELAY_CYCLES + 150 * 40 + 1000;
    localparam logic [31:0] LFSR_SEED = 32'ha289c895;

    // CASET 0..319, PASET 0..239, then memory write
    localparam spi_word_t WINDOW_REF [11] = '{
        9'h02A, 9'h100, 9'h100, 9'h101, 9'h13F,
        9'h02B, 9'h100, 9'h100, 9'h100, 9'h1EF,
        9'h02C
    };

    logic   clk;
    logic   rst;
    pixel_t input_data;
    logic   frame_done;
    logic   spi_mosi;
    logic   spi_sck;
    logic   spi_cs;
    logic   spi_dc;
    logic   data_clk;

    logic [31:0] lfsr_state;
    pixel_t      pixel_log [$];     // Pixels in the order presented
    spi_word_t   cap_words [$];     // {dc, byte} per cs rise
    int          cs_fall_cycle [$];
    int          cs_rise_cycle [$];
    int          cycle = 0;
    int          bit_count = 0;
    byte_t       shift_byte = '0;
    logic        prev_sck = 1'b0;
    logic        prev_cs = 1'b1;
    logic        last_data_clk = 1'b0;
    logic        compare_done = 1'b0;

    ili9341_controller #(
        .DELAY_CYCLES (DELAY_CYCLES)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .input_data (input_data),
        .frame_done (frame_done),
        .spi_mosi   (spi_mosi),
        .spi_sck    (spi_sck),
        .spi_cs     (spi_cs),
        .spi_dc     (spi_dc),
        .data_clk   (data_clk)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic fail_run(input string why);
        $display("*** TEST FAILED ***");
        $display("%s", why);
        $fatal(1);
    endtask

    task automatic check_value(input string name, input spi_word_t expected,
                               input spi_word_t actual);
        if (expected !== actual) begin
            fail_run($sformatf("mismatch %s: expected %03h, actual %03h",
                               name, expected, actual));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic present_pixel();
        pixel_t px;
        px = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            px = {px[14:0], lfsr_state[0]};
        end
        input_data = px;
        pixel_log.push_back(px);
    endtask

    // Expected word at stream position n
    function automatic spi_word_t expected_word(input int n);
        int     p;
        pixel_t px;
        p = n - PIXEL_BASE;
        if (n == 0) begin
            return {DC_CMD, CMD_SWRESET};
        end else if (n <= LAST_INIT) begin
            return INIT_TABLE[init_index_t'(n - 1)];
        end else if (n == DISPON_POS) begin
            return {DC_CMD, CMD_DISPON};
        end else if (n == DISPON_POS + 1) begin
            return {DC_CMD, CMD_MADCTL};
        end else if (n == DISPON_POS + 2) begin
            return {DC_DATA, 8'hE8};            // MY | MX | MV | BGR
        end else if (n < PIXEL_BASE) begin
            return WINDOW_REF[window_index_t'(n - WINDOW_BASE)];
        end
        px = pixel_log[p / 2];
        if (p % 2 == 0) begin
            return {DC_DATA, px[15:8]};         // High byte first
        end
        return {DC_DATA, px[7:0]};
    endfunction

    function automatic string word_name(input int n);
        if (n == 0) return "reset word";
        if (n <= LAST_INIT) return $sformatf("init word %0d", n);
        if (n == DISPON_POS) return "display on";
        if (n == DISPON_POS + 1) return "madctl command";
        if (n == DISPON_POS + 2) return "rotation value";
        if (n < PIXEL_BASE) return $sformatf("window word %0d", n - WINDOW_BASE);
        return $sformatf("pixel %0d %s byte", (n - PIXEL_BASE) / 2,
                         ((n - PIXEL_BASE) % 2 == 0) ? "high" : "low");
    endfunction

    // ------------------------------------------------------------
    // SPI monitor sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (rst) begin
            if (spi_cs !== 1'b1 || spi_sck !== 1'b0 || spi_mosi !== 1'b0 ||
                spi_dc !== 1'b0 || data_clk !== 1'b0) begin
                fail_run("SPI pins or data_clk not idle during reset");
            end
        end else begin
            if (!spi_cs && prev_cs) begin
                cs_fall_cycle.push_back(cycle);
                bit_count = 0;
            end
            if (!spi_cs && spi_sck && !prev_sck) begin
                shift_byte = {shift_byte[6:0], spi_mosi};   // MSB first
                bit_count  = bit_count + 1;
            end
            if (spi_cs && !prev_cs) begin
                if (bit_count != 8) begin
                    fail_run($sformatf("word %0d had %0d SCK pulses instead of 8",
                                       cap_words.size(), bit_count));
                end
                cap_words.push_back({spi_dc, shift_byte});
                cs_rise_cycle.push_back(cycle);
            end
        end
        prev_sck = spi_sck;
        prev_cs  = spi_cs;
    end

    // Next pixel once data_clk falls
    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (!rst && last_data_clk === 1'b1 && data_clk === 1'b0) begin
            present_pixel();
        end
        last_data_clk = data_clk;
    end

    // ------------------------------------------------------------
    // Compare captured words with the reference
    // ------------------------------------------------------------
    initial begin : compare
        int gap;
        for (int n = 0; n < TOTAL_WORDS; n++) begin
            while (cap_words.size() <= n) @(negedge clk);
            if (n >= PIXEL_BASE && pixel_log.size() <= (n - PIXEL_BASE) / 2) begin
                fail_run($sformatf("word %0d arrived before its pixel was presented", n));
            end
            check_value(word_name(n), expected_word(n), cap_words[n]);
            if (n == LAST_INIT) begin
                check_value("last init word", {DC_CMD, CMD_SLPOUT}, cap_words[n]);
            end
            // Waits follow SWRESET, SLPOUT and DISPON
            if (n == 1 || n == DISPON_POS || n == DISPON_POS + 1) begin
                gap = cs_fall_cycle[n] - cs_rise_cycle[n - 1];
                if (gap < DELAY_CYCLES) begin
                    fail_run($sformatf("delay after word %0d is %0d cycles, below %0d",
                                       n - 1, gap, DELAY_CYCLES));
                end
            end
        end
        compare_done = 1'b1;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run($sformatf("timeout after %0d cycles with %0d words captured",
                           WATCHDOG_CYCLES, cap_words.size()));
    end

    // ------------------------------------------------------------
    // Reset, frame pause and end of run
    // ------------------------------------------------------------
    initial begin : main
        int falls_at_pause;
        clk        = 1'b0;
        rst        = 1'b1;
        frame_done = 1'b0;
        lfsr_state = LFSR_SEED;
        present_pixel();                        // Pixel 0 waits for the first take
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        while (cs_fall_cycle.size() <= PIXEL_BASE + 2 * PAUSE_PIXEL) @(posedge clk);
        #DRIVE_DELAY;
        frame_done     = 1'b1;
        falls_at_pause = cs_fall_cycle.size();
        while (cap_words.size() < falls_at_pause) @(posedge clk);   // In-flight byte
        repeat (PAUSE_CYCLES) @(posedge clk);
        if (cs_fall_cycle.size() != falls_at_pause) begin
            fail_run("a new SPI word started while frame_done was high");
        end
        #DRIVE_DELAY;
        frame_done = 1'b0;

        while (!compare_done) @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
